// ==== compile.f ====
+incdir+verilog
verilog/sensor_pkg.sv
verilog/i2c_pkg.sv
verilog/i2c_xfer_if.sv
verilog/i2c_master.sv
verilog/sensor_poller.sv
verilog/reading_bank.sv
verilog/greenhouse_sensors.sv
dv/i2c_sensor_model.sv
dv/tb_greenhouse_sensors.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_greenhouse_sensors \
	-f compile.f || { echo "Build failed"; exit 1; }
result=$(./obj_dir/Vtb_greenhouse_sensors)
echo "$result"
echo "$result" | grep -q "^TEST PASS$" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== dv/tb_greenhouse_sensors.sv ====
`timescale 1ns/1ns
`include "greenhouse_settings.svh"

module tb_greenhouse_sensors
	import sensor_pkg::*;
();

localparam int SWEEPS = 12;
localparam int SWEEP_TIMEOUT = 20000;

logic clk;
logic rst;
logic scl;
logic sda_oe;
logic sda_in;
logic model_pull;
logic proto_err;
temp_t [NUM_TEMP-1:0] temp_c;
logic [NUM_TEMP-1:0] temp_valid;
lux_t [NUM_LUX-1:0] lux;
logic [NUM_LUX-1:0] lux_valid;
logic [7:0] fault;
logic sweep_done;

logic [7:0][15:0] words;
logic [7:0] present;
integer seed;

int exp_temp [NUM_TEMP];
int exp_lux [NUM_LUX];
logic [NUM_TEMP-1:0] exp_temp_valid;
logic [NUM_LUX-1:0] exp_lux_valid;
logic [7:0] exp_fault;

assign sda_in = !(sda_oe || model_pull); // Pulled up unless someone drives low

greenhouse_sensors uut (
	.clk(clk),
	.rst(rst),
	.scl(scl),
	.sda_oe(sda_oe),
	.sda_in(sda_in),
	.temp_c(temp_c),
	.temp_valid(temp_valid),
	.lux(lux),
	.lux_valid(lux_valid),
	.fault(fault),
	.sweep_done(sweep_done)
);

i2c_sensor_model sensors (
	.clk(clk),
	.rst(rst),
	.scl(scl),
	.sda(sda_in),
	.words(words),
	.present(present),
	.sda_pull(model_pull),
	.proto_err(proto_err)
);

always #2 clk = ~clk;

// Upper nine bits, two's complement half degrees
function automatic int expected_temp(input logic [15:0] w);
	return int'($signed(w[15:7]));
endfunction

// Mantissa times two to the exponent, over 100, clipped to 16 bits
function automatic int expected_lux(input logic [15:0] w);
	longint raw;
	raw = longint'(w[11:0]) * (longint'(1) << w[15:12]);
	raw = raw / 100;
	return (raw > 65535) ? 65535 : int'(raw);
endfunction

task automatic abort_run();
	$display("TEST FAIL");
	$fatal(1);
endtask

task automatic compare_value(input string name, input int expected, input int actual);
	assert (actual == expected)
	else
	begin
		$display("FAIL time=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
		abort_run();
	end
endtask

task automatic randomize_sensors();
	for (int i = 0; i < 8; i++)
	begin
		words[i] = 16'($random(seed));
		present[i] = (($random(seed) & 3) != 0); // Absent about one time in four
	end
endtask

task automatic apply_sweep_to_model();
	for (int i = 0; i < 8; i++)
	begin
		exp_fault[i] = !present[i];
		if (present[i] && i < NUM_TEMP)
		begin
			exp_temp[i] = expected_temp(words[i]);
			exp_temp_valid[i] = 1'b1;
		end
		else if (present[i])
		begin
			exp_lux[i - NUM_TEMP] = expected_lux(words[i]);
			exp_lux_valid[i - NUM_TEMP] = 1'b1;
		end
	end
endtask

task automatic check_reset_state();
	compare_value("scl", 1, int'(scl));
	compare_value("sda_oe", 0, int'(sda_oe));
	compare_value("temp_valid", 0, int'(temp_valid));
	compare_value("lux_valid", 0, int'(lux_valid));
	compare_value("fault", 0, int'(fault));
	compare_value("sweep_done", 0, int'(sweep_done));
	for (int i = 0; i < NUM_TEMP; i++)
		compare_value($sformatf("temp_c[%0d]", i), 0, int'($signed(temp_c[i])));
	for (int i = 0; i < NUM_LUX; i++)
		compare_value($sformatf("lux[%0d]", i), 0, int'(lux[i]));
endtask

task automatic check_sweep_outputs();
	for (int i = 0; i < NUM_TEMP; i++)
	begin
		compare_value($sformatf("temp_c[%0d]", i), exp_temp[i], int'($signed(temp_c[i])));
		compare_value($sformatf("temp_valid[%0d]", i), int'(exp_temp_valid[i]),
			int'(temp_valid[i]));
	end
	for (int i = 0; i < NUM_LUX; i++)
	begin
		compare_value($sformatf("lux[%0d]", i), exp_lux[i], int'(lux[i]));
		compare_value($sformatf("lux_valid[%0d]", i), int'(exp_lux_valid[i]), int'(lux_valid[i]));
	end
	compare_value("fault", int'(exp_fault), int'(fault));
endtask

task automatic wait_sweep_done();
	int cycles;
	cycles = 0;
	@(negedge clk);
	while (!sweep_done && cycles < SWEEP_TIMEOUT)
	begin
		@(negedge clk);
		cycles++;
	end
	assert (sweep_done)
	else
	begin
		$display("Timed out after %0d cycles waiting for sweep_done", SWEEP_TIMEOUT);
		abort_run();
	end
endtask

always @(posedge clk)
begin
	assert (!proto_err)
	else
	begin
		$display("Sensor model reported a bus protocol error");
		abort_run();
	end
end

initial
begin
	clk = 1'b0;
	rst = 1'b1;
	seed = 31;
	words = '0;
	present = '0;
	exp_temp_valid = '0;
	exp_lux_valid = '0;
	exp_fault = '0;
	for (int i = 0; i < NUM_TEMP; i++)
		exp_temp[i] = 0;
	for (int i = 0; i < NUM_LUX; i++)
		exp_lux[i] = 0;
	randomize_sensors(); // Values for the first sweep
	repeat (3) @(posedge clk);
	#1;
	rst = 1'b0;
	repeat (`POLL_GAP / 2) // Bus stays idle until the first request
	begin
		@(negedge clk);
		check_reset_state();
	end
	for (int s = 0; s < SWEEPS; s++)
	begin
		wait_sweep_done();
		apply_sweep_to_model();
		check_sweep_outputs();
		@(posedge clk);
		#1;
		randomize_sensors(); // Poll gap covers the change
	end
	$display("TEST PASS");
	$finish;
end

endmodule

// ==== dv/i2c_sensor_model.sv ====
`timescale 1ns/1ns
`include "greenhouse_settings.svh"

module i2c_sensor_model (
	input logic clk,
	input logic rst,
	input logic scl,
	input logic sda, // Resolved line
	input logic [7:0][15:0] words, // Raw word per sensor, sweep order
	input logic [7:0] present,
	output logic sda_pull,
	output logic proto_err
);

typedef enum logic [2:0] {
	M_IDLE,
	M_ADDR,
	M_ACK,
	M_SEND,
	M_MACK,
	M_MNACK,
	M_WAIT_STOP
} slave_state_t;

slave_state_t state;
logic prev_scl;
logic prev_sda;
logic next_pull;
logic [3:0] bit_cnt;
logic second_byte;
logic acked;
logic [7:0] rx_byte;
logic [15:0] tx_word;
logic [2:0] exp_idx; // Next sensor expected on the bus

function automatic logic [6:0] sweep_addr(input logic [2:0] idx);
	case (idx)
	3'd0: return `SOLAR_ADDR;
	3'd1: return `GREENHOUSE_ADDR;
	3'd2: return `AMBIENT_ADDR;
	3'd3: return `GEOTHERMAL_ADDR;
	3'd4: return `NORTH_ADDR;
	3'd5: return `EAST_ADDR;
	3'd6: return `SOUTH_ADDR;
	default: return `WEST_ADDR;
	endcase
endfunction

task automatic flag_error(input string what);
	$display("Bus protocol error at time %0t: %s", $time, what);
	proto_err = 1'b1;
endtask

task automatic drive_next_bit();
	next_pull = !tx_word[15]; // MSB first
	tx_word = tx_word << 1;
endtask

initial
begin
	sda_pull = 1'b0;
	next_pull = 1'b0;
	proto_err = 1'b0;
end

// Bus lines sampled mid cycle where they are settled
always @(negedge clk)
begin
	if (rst)
	begin
		state = M_IDLE;
		prev_scl = 1'b1;
		prev_sda = 1'b1;
		next_pull = 1'b0;
		bit_cnt = '0;
		exp_idx = '0;
	end
	else
	begin
		if (prev_scl && scl && prev_sda && !sda)
		begin
			assert (state == M_IDLE) else flag_error("START inside a transaction");
			state = M_ADDR;
			bit_cnt = '0;
		end
		else if (prev_scl && scl && !prev_sda && sda)
		begin
			assert (state == M_WAIT_STOP) else flag_error("STOP before the transaction was complete");
			state = M_IDLE;
			exp_idx = exp_idx + 3'd1;
		end
		else if (!prev_scl && scl)
		begin
			case (state)
			M_ADDR:
			begin
				rx_byte = {rx_byte[6:0], sda};
				bit_cnt = bit_cnt + 4'd1;
				if (bit_cnt == 4'd8)
				begin
					assert (rx_byte[0]) else flag_error("write bit in the address byte");
					assert (rx_byte[7:1] == sweep_addr(exp_idx))
					else
					begin
						$display("FAIL time=%0t address expected=0x%h actual=0x%h", $time,
							sweep_addr(exp_idx), rx_byte[7:1]);
						proto_err = 1'b1;
					end
					acked = present[exp_idx];
					tx_word = words[exp_idx];
				end
			end
			M_SEND: bit_cnt = bit_cnt + 4'd1;
			M_MACK: assert (!sda) else flag_error("master did not acknowledge the first byte");
			M_MNACK: assert (sda) else flag_error("master acknowledged the last byte");
			default: ;
			endcase
		end
		else if (prev_scl && !scl)
		begin
			case (state)
			M_IDLE: flag_error("SCL clocked outside a transaction");
			M_ADDR:
				if (bit_cnt == 4'd8)
				begin
					next_pull = acked; // Address ack only when present
					state = M_ACK;
				end
			M_ACK:
				if (acked)
				begin
					drive_next_bit();
					bit_cnt = '0;
					second_byte = 1'b0;
					state = M_SEND;
				end
				else
					state = M_WAIT_STOP;
			M_SEND:
				if (bit_cnt == 4'd8)
				begin
					next_pull = 1'b0; // Hand SDA to the master
					state = second_byte ? M_MNACK : M_MACK;
				end
				else
					drive_next_bit();
			M_MACK:
			begin
				drive_next_bit();
				bit_cnt = '0;
				second_byte = 1'b1;
				state = M_SEND;
			end
			M_MNACK: state = M_WAIT_STOP;
			default: ;
			endcase
		end
		prev_scl = scl;
		prev_sda = sda;
	end
end

always @(posedge clk)
begin
	#1;
	sda_pull = next_pull;
end

endmodule

// ==== verilog/greenhouse_sensors.sv ====
`timescale 1ns/1ns

module greenhouse_sensors
	import sensor_pkg::*;
(
	input logic clk,
	input logic rst,
	output logic scl,
	output logic sda_oe,
	input logic sda_in,
	output temp_t [NUM_TEMP-1:0] temp_c,
	output logic [NUM_TEMP-1:0] temp_valid,
	output lux_t [NUM_LUX-1:0] lux,
	output logic [NUM_LUX-1:0] lux_valid,
	output logic [7:0] fault,
	output logic sweep_done
);

i2c_xfer_if xfer ();

logic temp_wr_en;
logic lux_wr_en;
logic [1:0] wr_idx; // Shared by both banks
temp_t temp_wr_data;
lux_t lux_wr_data;

i2c_master u_master (
	.clk(clk),
	.rst(rst),
	.bus(xfer.engine),
	.scl(scl),
	.sda_oe(sda_oe),
	.sda_in(sda_in)
);

sensor_poller u_poller (
	.clk(clk),
	.rst(rst),
	.bus(xfer.requester),
	.temp_wr_en(temp_wr_en),
	.lux_wr_en(lux_wr_en),
	.wr_idx(wr_idx),
	.temp_wr_data(temp_wr_data),
	.lux_wr_data(lux_wr_data),
	.fault(fault),
	.sweep_done(sweep_done)
);

reading_bank #(.reading_t(temp_t), .DEPTH(NUM_TEMP)) u_temp_bank (
	.clk(clk),
	.rst(rst),
	.wr_en(temp_wr_en),
	.wr_idx(wr_idx),
	.wr_data(temp_wr_data),
	.values(temp_c),
	.valid(temp_valid)
);

reading_bank #(.reading_t(lux_t), .DEPTH(NUM_LUX)) u_lux_bank (
	.clk(clk),
	.rst(rst),
	.wr_en(lux_wr_en),
	.wr_idx(wr_idx),
	.wr_data(lux_wr_data),
	.values(lux),
	.valid(lux_valid)
);

endmodule

// ==== verilog/reading_bank.sv ====
`timescale 1ns/1ns

module reading_bank
	import sensor_pkg::*;
#(
	parameter type reading_t = lux_t,
	parameter int DEPTH = NUM_LUX
) (
	input logic clk,
	input logic rst,
	input logic wr_en,
	input logic [$clog2(DEPTH)-1:0] wr_idx,
	input reading_t wr_data,
	output reading_t [DEPTH-1:0] values,
	output logic [DEPTH-1:0] valid
);

always_ff @(posedge clk)
begin
	if (rst)
	begin
		values <= '0;
		valid <= '0;
	end
	else if (wr_en)
	begin
		values[wr_idx] <= wr_data;
		valid[wr_idx] <= 1'b1; // Sticky until reset
	end
end

endmodule

// ==== verilog/sensor_poller.sv ====
`timescale 1ns/1ns
`include "greenhouse_settings.svh"

module sensor_poller
	import sensor_pkg::*;
	import i2c_pkg::*;
(
	input logic clk,
	input logic rst,
	i2c_xfer_if.requester bus,
	output logic temp_wr_en,
	output logic lux_wr_en,
	output logic [1:0] wr_idx,
	output temp_t temp_wr_data,
	output lux_t lux_wr_data,
	output logic [7:0] fault,
	output logic sweep_done
);

localparam int GAP_W = $clog2(`POLL_GAP + 1);
localparam logic [GAP_W-1:0] GAP_LOAD = GAP_W'(`POLL_GAP - 1);

sensor_id_t cur;
logic [GAP_W-1:0] gap_cnt;
logic in_gap;
logic req_valid;
i2c_addr_t addr;
i2c_word_t word;
logic rsp_ok;
logic [26:0] lux_shifted; // 12 bit mantissa shifted up to 15
logic [26:0] lux_scaled;

always_comb
begin
	case (cur)
	SENSOR_SOLAR: addr = `SOLAR_ADDR;
	SENSOR_GREENHOUSE: addr = `GREENHOUSE_ADDR;
	SENSOR_AMBIENT: addr = `AMBIENT_ADDR;
	SENSOR_GEOTHERMAL: addr = `GEOTHERMAL_ADDR;
	SENSOR_NORTH: addr = `NORTH_ADDR;
	SENSOR_EAST: addr = `EAST_ADDR;
	SENSOR_SOUTH: addr = `SOUTH_ADDR;
	default: addr = `WEST_ADDR;
	endcase
end

assign bus.req_valid = req_valid;
assign bus.req_addr = addr;
assign word = bus.rsp_word;

// Word to reading conversion
assign temp_wr_data = temp_t'(word[15:7]);
assign lux_shifted = {15'd0, word[11:0]} << word[15:12];
assign lux_scaled = lux_shifted / 27'd100;
assign lux_wr_data = (lux_scaled > 27'd65535) ? 16'hffff : lux_scaled[15:0]; // Saturate

assign rsp_ok = bus.rsp_valid && !bus.rsp_nack;
assign temp_wr_en = rsp_ok && (class_of(cur) == CLASS_TEMP);
assign lux_wr_en = rsp_ok && (class_of(cur) == CLASS_LUX);
assign wr_idx = cur[1:0]; // Position within its class

always_ff @(posedge clk)
begin
	if (rst)
	begin
		cur <= SENSOR_SOLAR;
		gap_cnt <= GAP_LOAD;
		in_gap <= 1'b1;
		req_valid <= 1'b0;
		fault <= '0;
		sweep_done <= 1'b0;
	end
	else
	begin
		sweep_done <= 1'b0;
		if (in_gap)
		begin
			if (gap_cnt == '0)
			begin
				in_gap <= 1'b0;
				req_valid <= 1'b1;
			end
			else
				gap_cnt <= gap_cnt - 1'b1;
		end
		if (req_valid && bus.req_ready)
			req_valid <= 1'b0;
		if (bus.rsp_valid)
		begin
			fault[cur] <= bus.rsp_nack; // A good read clears the bit
			cur <= sensor_id_t'(cur + 3'd1);
			if (cur == SENSOR_WEST)
			begin
				sweep_done <= 1'b1;
				in_gap <= 1'b1;
				gap_cnt <= GAP_LOAD;
			end
			else
				req_valid <= 1'b1;
		end
	end
end

endmodule

// ==== verilog/i2c_master.sv ====
`timescale 1ns/1ns
`include "greenhouse_settings.svh"

module i2c_master
	import i2c_pkg::*;
(
	input logic clk,
	input logic rst,
	i2c_xfer_if.engine bus,
	output logic scl,
	output logic sda_oe,
	input logic sda_in
);

// Each bit spans one SCL period split into ticks of the divider count
localparam int HALF = `SCL_HALF;
localparam int CNT_W = $clog2(2 * HALF);
localparam logic [CNT_W-1:0] T_DRIVE = CNT_W'(HALF / 2); // Middle of SCL low
localparam logic [CNT_W-1:0] T_RISE = CNT_W'(HALF);
localparam logic [CNT_W-1:0] T_SAMPLE = CNT_W'(HALF + HALF / 2); // Middle of SCL high
localparam logic [CNT_W-1:0] T_LAST = CNT_W'(2 * HALF - 1);

i2c_phase_t phase;
logic [CNT_W-1:0] cnt;
logic [2:0] bit_cnt;
logic [7:0] tx_byte;
i2c_word_t rx_word;
logic nack;
logic rsp_pend;
logic done;
logic bit_end;

assign bit_end = (cnt == T_LAST);
assign bus.req_ready = (phase == I2C_IDLE) && !rsp_pend;
assign bus.rsp_valid = done;
assign bus.rsp_word = rx_word;
assign bus.rsp_nack = nack;

always_ff @(posedge clk)
begin
	if (rst)
	begin
		phase <= I2C_IDLE;
		cnt <= '0;
		bit_cnt <= '0;
		scl <= 1'b1;
		sda_oe <= 1'b0;
		nack <= 1'b0;
		rsp_pend <= 1'b0;
		done <= 1'b0;
	end
	else
	begin
		done <= rsp_pend; // One cycle after the stop condition
		rsp_pend <= 1'b0;
		if (phase == I2C_IDLE)
			cnt <= '0;
		else if (bit_end)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;

		// Start keeps SCL high, every other phase clocks one bit
		if (phase != I2C_IDLE && phase != I2C_START)
		begin
			if (cnt == '0)
				scl <= 1'b0;
			else if (cnt == T_RISE)
				scl <= 1'b1;
		end

		case (phase)
		I2C_IDLE:
			if (bus.req_valid && bus.req_ready)
			begin
				tx_byte <= {bus.req_addr, 1'b1}; // Read bit
				phase <= I2C_START;
			end
		I2C_START:
			if (cnt == T_RISE)
				sda_oe <= 1'b1; // SDA falls under high SCL
			else if (bit_end)
				phase <= I2C_ADDR;
		I2C_ADDR:
			if (cnt == T_DRIVE)
				sda_oe <= ~tx_byte[7];
			else if (bit_end)
			begin
				tx_byte <= {tx_byte[6:0], 1'b0};
				bit_cnt <= bit_cnt + 1'b1; // Wraps back to zero after the byte
				if (bit_cnt == 3'd7)
					phase <= I2C_ADDR_ACK;
			end
		I2C_ADDR_ACK:
			if (cnt == T_DRIVE)
				sda_oe <= 1'b0;
			else if (cnt == T_SAMPLE)
				nack <= sda_in;
			else if (bit_end)
				phase <= nack ? I2C_STOP : I2C_READ_HI; // Skip both data bytes
		I2C_READ_HI, I2C_READ_LO:
			if (cnt == T_DRIVE)
				sda_oe <= 1'b0;
			else if (cnt == T_SAMPLE)
				rx_word <= {rx_word[14:0], sda_in};
			else if (bit_end)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == 3'd7)
					phase <= (phase == I2C_READ_HI) ? I2C_ACK_HI : I2C_NACK_LO;
			end
		I2C_ACK_HI:
			if (cnt == T_DRIVE)
				sda_oe <= 1'b1; // Ask for the low byte
			else if (bit_end)
				phase <= I2C_READ_LO;
		I2C_NACK_LO:
			if (cnt == T_DRIVE)
				sda_oe <= 1'b0;
			else if (bit_end)
				phase <= I2C_STOP;
		I2C_STOP:
			if (cnt == T_DRIVE)
				sda_oe <= 1'b1;
			else if (bit_end)
			begin
				sda_oe <= 1'b0; // SDA rises under high SCL
				phase <= I2C_IDLE;
				rsp_pend <= 1'b1;
			end
		default:
			phase <= I2C_IDLE;
		endcase
	end
end

endmodule

// ==== verilog/i2c_xfer_if.sv ====
`timescale 1ns/1ns

interface i2c_xfer_if
	import sensor_pkg::*;
	import i2c_pkg::*;
();

	logic req_valid;
	logic req_ready; // High only while the engine is idle
	i2c_addr_t req_addr;
	logic rsp_valid; // Single cycle pulse
	i2c_word_t rsp_word;
	logic rsp_nack; // Address was not acknowledged

	modport requester (output req_valid, output req_addr, input req_ready,
		input rsp_valid, input rsp_word, input rsp_nack);

	modport engine (input req_valid, input req_addr, output req_ready,
		output rsp_valid, output rsp_word, output rsp_nack);

endinterface

// ==== verilog/i2c_pkg.sv ====
package i2c_pkg;

	// Bus phases of one two-byte read
	typedef enum logic [3:0] {
		I2C_IDLE,
		I2C_START,
		I2C_ADDR,
		I2C_ADDR_ACK,
		I2C_READ_HI,
		I2C_ACK_HI,
		I2C_READ_LO,
		I2C_NACK_LO,
		I2C_STOP
	} i2c_phase_t;

	typedef logic [15:0] i2c_word_t; // MSB byte arrives first

endpackage

// ==== verilog/sensor_pkg.sv ====
package sensor_pkg;

	// Sweep order, temperatures first
	typedef enum logic [2:0] {
		SENSOR_SOLAR,
		SENSOR_GREENHOUSE,
		SENSOR_AMBIENT,
		SENSOR_GEOTHERMAL,
		SENSOR_NORTH,
		SENSOR_EAST,
		SENSOR_SOUTH,
		SENSOR_WEST
	} sensor_id_t;

	typedef logic signed [8:0] temp_t; // Half degree steps
	typedef logic [15:0] lux_t;
	typedef logic [6:0] i2c_addr_t;

	localparam int NUM_TEMP = 4;
	localparam int NUM_LUX = 4;

	typedef enum logic {CLASS_TEMP, CLASS_LUX} sensor_class_t;

	function automatic sensor_class_t class_of(input sensor_id_t id);
		return id[2] ? CLASS_LUX : CLASS_TEMP; // Upper half of the sweep is light
	endfunction

endpackage

// ==== verilog/greenhouse_settings.svh ====
`ifndef GREENHOUSE_SETTINGS_SVH
`define GREENHOUSE_SETTINGS_SVH

// Bus pacing
`define SCL_HALF 4 // System clocks per SCL half period
`define POLL_GAP 16 // Idle clocks between sweeps

// Temperature sensors
`define SOLAR_ADDR 7'h48
`define GREENHOUSE_ADDR 7'h49
`define AMBIENT_ADDR 7'h4a
`define GEOTHERMAL_ADDR 7'h4b

// Light sensors
`define NORTH_ADDR 7'h44
`define EAST_ADDR 7'h45
`define SOUTH_ADDR 7'h46
`define WEST_ADDR 7'h47

`endif
